//--- cdc_reset_ctrlr.f
+incdir+src
src/cdc_reset_phase_pkg.sv
src/cdc_reset_link_pkg.sv
src/clear_initiator.sv
src/clear_receiver.sv
src/phase_cdc_src.sv
src/phase_cdc_dst.sv
src/cdc_reset_ctrlr_half.sv
src/cdc_reset_ctrlr.sv
verification/tb_clk_gen.sv
verification/tb_cdc_reset_ctrlr.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log for failures
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Mdir obj_dir \
  --top-module tb_cdc_reset_ctrlr -f cdc_reset_ctrlr.f
./obj_dir/Vtb_cdc_reset_ctrlr > sim.log 2>&1
cat sim.log
if grep -q "Errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

//--- src/cdc_reset_ctrlr.sv
//--------------------------------------------------
// clear-sequence controller top level
// two domain halves cross-wired by a pair of
// 4-phase phase crossings
//--------------------------------------------------

`timescale 1ns/100ps

module cdc_reset_ctrlr
  import cdc_reset_phase_pkg::*;
  import cdc_reset_link_pkg::*;
(
  input  logic      a_clk_i,
  input  logic      a_rst_ni,
  input  logic      a_clear_i,
  input  side_ack_t a_ack_i,
  output side_cmd_t a_cmd_o,
  input  logic      b_clk_i,
  input  logic      b_rst_ni,
  input  logic      b_clear_i,
  input  side_ack_t b_ack_i,
  output side_cmd_t b_cmd_o
);

  // async signals between the domains, named by direction
  phase_link_t link_a2b;
  phase_link_t link_b2a;
  logic        ack_a2b;
  logic        ack_b2a;

  cdc_reset_ctrlr_half i_half_a (
    .clk_i      (a_clk_i),
    .rst_ni     (a_rst_ni),
    .clear_i    (a_clear_i),
    .ack_i      (a_ack_i),
    .cmd_o      (a_cmd_o),
    .link_o     (link_a2b),
    .link_ack_i (ack_b2a),
    .link_i     (link_b2a),
    .link_ack_o (ack_a2b)
  );

  cdc_reset_ctrlr_half i_half_b (
    .clk_i      (b_clk_i),
    .rst_ni     (b_rst_ni),
    .clear_i    (b_clear_i),
    .ack_i      (b_ack_i),
    .cmd_o      (b_cmd_o),
    .link_o     (link_b2a),
    .link_ack_i (ack_a2b),
    .link_i     (link_a2b),
    .link_ack_o (ack_b2a)
  );

endmodule

//--- src/cdc_reset_ctrlr_consts.svh
//--------------------------------------------------
// build-time constants of the clear-sequence controller
// synchronizer depth, async reset behaviour and the
// phase code sent as the reset message
//--------------------------------------------------

`ifndef CDC_RESET_CTRLR_CONSTS_SVH
`define CDC_RESET_CTRLR_CONSTS_SVH

// flip-flops in every request or acknowledge synchronizer
`define CRC_SYNC_STAGES 2

// 1 makes an async reset start a clear sequence and send the reset message
`define CRC_CLEAR_ON_ASYNC_RESET 1

// width of the phase code carried across the crossing
`define CRC_PHASE_W 2

// phase code the crossing source presents while in reset (ISOLATE)
`define CRC_RESET_MSG_PHASE 2'd1

`endif

//--- src/cdc_reset_ctrlr_half.sv
//--------------------------------------------------
// controller of one clock domain
// initiator, receiver and both crossing halves,
// commands of initiator and receiver ORed together
//--------------------------------------------------

`timescale 1ns/100ps

module cdc_reset_ctrlr_half
  import cdc_reset_phase_pkg::*;
  import cdc_reset_link_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  side_ack_t   ack_i,
  output side_cmd_t   cmd_o,
  output phase_link_t link_o,
  input  logic        link_ack_i,
  input  phase_link_t link_i,
  output logic        link_ack_o
);

  // ------------------------------------------------
  // local sequence, sent to the other domain
  // ------------------------------------------------

  logic         init_valid;
  logic         init_ready;
  clear_phase_e init_phase;
  side_cmd_t    init_cmd;

  clear_initiator i_clear_initiator (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .ack_i         (ack_i),
    .phase_valid_o (init_valid),
    .phase_o       (init_phase),
    .phase_ready_i (init_ready),
    .cmd_o         (init_cmd)
  );

  phase_cdc_src i_phase_cdc_src (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .phase_i    (init_phase),
    .valid_i    (init_valid),
    .ready_o    (init_ready),
    .link_o     (link_o),
    .link_ack_i (link_ack_i)
  );

  // ------------------------------------------------
  // sequence started by the other domain
  // ------------------------------------------------

  logic         rx_valid;
  logic         rx_ready;
  clear_phase_e rx_phase;
  side_cmd_t    rx_cmd;

  phase_cdc_dst i_phase_cdc_dst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .link_i     (link_i),
    .link_ack_o (link_ack_o),
    .valid_o    (rx_valid),
    .phase_o    (rx_phase),
    .ready_i    (rx_ready)
  );

  clear_receiver i_clear_receiver (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .ack_i   (ack_i),
    .valid_i (rx_valid),
    .phase_i (rx_phase),
    .ready_o (rx_ready),
    .cmd_o   (rx_cmd)
  );

  // both sequences follow the same order, so their OR does as well
  // even when both domains start a clear at the same time
  assign cmd_o.isolate = init_cmd.isolate | rx_cmd.isolate;
  assign cmd_o.clear   = init_cmd.clear | rx_cmd.clear;

  // clear from either source must sit inside an isolate window opened before it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_o.clear |-> cmd_o.isolate && $past(cmd_o.isolate));

endmodule

//--- src/cdc_reset_link_pkg.sv
//--------------------------------------------------
// types of the signals that cross between the two
// clock domains of the clear-sequence controller
//--------------------------------------------------

`include "cdc_reset_ctrlr_consts.svh"

package cdc_reset_link_pkg;

  import cdc_reset_phase_pkg::*;

  // request of the 4-phase crossing with the phase it carries
  // the phase is bundled data and stays stable while req is high
  typedef struct packed {
    logic         req;
    clear_phase_e phase;
  } phase_link_t;

  // shift register of one synchronizer, bit 0 samples the async input
  typedef logic [`CRC_SYNC_STAGES-1:0] sync_vec_t;

endpackage

//--- src/cdc_reset_phase_pkg.sv
//--------------------------------------------------
// clear-sequence phase code and the command and
// acknowledge bundles exchanged with one CDC side
//--------------------------------------------------

`include "cdc_reset_ctrlr_consts.svh"

package cdc_reset_phase_pkg;

  // the four phases every clear sequence walks through
  // the codes must agree with CRC_RESET_MSG_PHASE in the constants header
  typedef enum logic [`CRC_PHASE_W-1:0] {
    CLEAR_PHASE_IDLE       = 2'd0,
    CLEAR_PHASE_ISOLATE    = 2'd1,
    CLEAR_PHASE_CLEAR      = 2'd2,
    CLEAR_PHASE_POST_CLEAR = 2'd3
  } clear_phase_e;

  // commands to one CDC side, clear is only ever high together with isolate
  typedef struct packed {
    logic isolate;
    logic clear;
  } side_cmd_t;

  // level acknowledges returned by one CDC side
  typedef struct packed {
    logic isolate_ack;
    logic clear_ack;
  } side_ack_t;

endpackage

//--- src/clear_initiator.sv
//--------------------------------------------------
// clear-sequence initiator FSM
// started by clear_i or by async reset, drives the
// local commands and hands each phase to the crossing
//--------------------------------------------------

`timescale 1ns/100ps

`include "cdc_reset_ctrlr_consts.svh"

module clear_initiator
  import cdc_reset_phase_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  side_ack_t    ack_i,
  output logic         phase_valid_o,
  output clear_phase_e phase_o,
  input  logic         phase_ready_i,
  output side_cmd_t    cmd_o
);

  // the WAIT_* states remember which of the two conditions of a phase already arrived
  typedef enum logic [3:0] {
    IDLE,
    ISOLATE,
    WAIT_ISOLATE_PHASE_ACK,
    WAIT_ISOLATE_ACK,
    CLEAR,
    WAIT_CLEAR_PHASE_ACK,
    WAIT_CLEAR_ACK,
    POST_CLEAR,
    FINISHED
  } state_e;

  // with the async-clear switch on, leaving reset is itself the start of a sequence
  localparam state_e ResetState = (`CRC_CLEAR_ON_ASYNC_RESET != 0) ? ISOLATE : IDLE;

  state_e state_q;
  state_e state_d;

  always_comb begin
    state_d       = state_q;
    phase_valid_o = 1'b0;
    phase_o       = CLEAR_PHASE_IDLE;
    cmd_o         = '0;
    case (state_q)
      IDLE: begin
        if (clear_i) begin
          state_d = ISOLATE;
        end
      end
      // local isolate ack and the far side's phase ack may come in either order
      ISOLATE, WAIT_ISOLATE_PHASE_ACK, WAIT_ISOLATE_ACK: begin
        cmd_o.isolate = 1'b1;
        phase_o       = CLEAR_PHASE_ISOLATE;
        phase_valid_o = (state_q != WAIT_ISOLATE_ACK);
        if (state_q == ISOLATE) begin
          if (phase_ready_i && ack_i.isolate_ack) begin
            state_d = CLEAR;
          end else if (phase_ready_i) begin
            state_d = WAIT_ISOLATE_ACK;
          end else if (ack_i.isolate_ack) begin
            state_d = WAIT_ISOLATE_PHASE_ACK;
          end
        end else if (state_q == WAIT_ISOLATE_ACK ? ack_i.isolate_ack : phase_ready_i) begin
          state_d = CLEAR;
        end
      end
      CLEAR, WAIT_CLEAR_PHASE_ACK, WAIT_CLEAR_ACK: begin
        cmd_o         = '{isolate: 1'b1, clear: 1'b1};
        phase_o       = CLEAR_PHASE_CLEAR;
        phase_valid_o = (state_q != WAIT_CLEAR_ACK);
        if (state_q == CLEAR) begin
          if (phase_ready_i && ack_i.clear_ack) begin
            state_d = POST_CLEAR;
          end else if (phase_ready_i) begin
            state_d = WAIT_CLEAR_ACK;
          end else if (ack_i.clear_ack) begin
            state_d = WAIT_CLEAR_PHASE_ACK;
          end
        end else if (state_q == WAIT_CLEAR_ACK ? ack_i.clear_ack : phase_ready_i) begin
          state_d = POST_CLEAR;
        end
      end
      // clear released, isolate held until the far side has left clear too
      POST_CLEAR: begin
        cmd_o.isolate = 1'b1;
        phase_o       = CLEAR_PHASE_POST_CLEAR;
        phase_valid_o = 1'b1;
        if (phase_ready_i) begin
          state_d = FINISHED;
        end
      end
      // isolate drops only after the far side has taken the IDLE phase
      FINISHED: begin
        cmd_o.isolate = 1'b1;
        phase_valid_o = 1'b1;
        if (phase_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = ISOLATE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetState;
    end else begin
      state_q <= state_d;
    end
  end

  // clear may only be released once the side has acknowledged it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_o.clear && !ack_i.clear_ack |=> cmd_o.clear);

endmodule

//--- src/clear_receiver.sv
//--------------------------------------------------
// clear-sequence receiver
// follows the phases sent by the other domain and
// acknowledges each once the local side has done so
//--------------------------------------------------

`timescale 1ns/100ps

module clear_receiver
  import cdc_reset_phase_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  side_ack_t    ack_i,
  input  logic         valid_i,
  input  clear_phase_e phase_i,
  output logic         ready_o,
  output side_cmd_t    cmd_o
);

  clear_phase_e phase_q;
  clear_phase_e cur_phase;

  // last phase handed over by the other domain
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= CLEAR_PHASE_IDLE;
    end else if (valid_i && ready_o) begin
      phase_q <= phase_i;
    end
  end

  // an offered phase drives the commands at once so the local side can ack it
  assign cur_phase = valid_i ? phase_i : phase_q;

  always_comb begin
    cmd_o = '0;
    case (cur_phase)
      CLEAR_PHASE_ISOLATE:    cmd_o.isolate = 1'b1;
      CLEAR_PHASE_CLEAR:      cmd_o = '{isolate: 1'b1, clear: 1'b1};
      CLEAR_PHASE_POST_CLEAR: cmd_o.isolate = 1'b1;
      default:                cmd_o = '0;
    endcase
  end

  // isolate and clear need the matching side ack
  // leaving clear or isolate needs nothing from the side
  always_comb begin
    ready_o = 1'b0;
    if (valid_i) begin
      case (phase_i)
        CLEAR_PHASE_IDLE:       ready_o = 1'b1;
        CLEAR_PHASE_ISOLATE:    ready_o = ack_i.isolate_ack;
        CLEAR_PHASE_CLEAR:      ready_o = ack_i.clear_ack;
        CLEAR_PHASE_POST_CLEAR: ready_o = 1'b1;
        default:                ready_o = 1'b0;
      endcase
    end
  end

endmodule

//--- src/phase_cdc_dst.sv
//--------------------------------------------------
// destination half of the 4-phase phase crossing
// synchronizes req, offers the phase locally and
// acks it once the local receiver has taken it
//--------------------------------------------------

`timescale 1ns/100ps

`include "cdc_reset_ctrlr_consts.svh"

module phase_cdc_dst
  import cdc_reset_phase_pkg::*;
  import cdc_reset_link_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  phase_link_t  link_i,
  output logic         link_ack_o,
  output logic         valid_o,
  output clear_phase_e phase_o,
  input  logic         ready_i
);

  sync_vec_t req_sync_q;
  logic      req_sync;
  logic      ack_q;

  assign req_sync = req_sync_q[`CRC_SYNC_STAGES-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_sync_q <= '0;
    end else begin
      req_sync_q <= sync_vec_t'({req_sync_q, link_i.req});
    end
  end

  // ack rises when the phase is accepted and falls once req is seen low
  // a reset on this side drops ack and lets a pending request be offered again
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else if (valid_o && ready_i) begin
      ack_q <= 1'b1;
    end else if (!req_sync) begin
      ack_q <= 1'b0;
    end
  end

  // the phase is stable while req is high, so it is read directly
  assign phase_o    = link_i.phase;
  assign valid_o    = req_sync && !ack_q;
  assign link_ack_o = ack_q;

endmodule

//--- src/phase_cdc_src.sv
//--------------------------------------------------
// source half of the 4-phase phase crossing
// a transfer ends only after the far side dropped ack
// in reset it already requests the ISOLATE phase
//--------------------------------------------------

`timescale 1ns/100ps

`include "cdc_reset_ctrlr_consts.svh"

module phase_cdc_src
  import cdc_reset_phase_pkg::*;
  import cdc_reset_link_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  clear_phase_e phase_i,
  input  logic         valid_i,
  output logic         ready_o,
  output phase_link_t  link_o,
  input  logic         link_ack_i
);

  // reset message, req stays high however long the reset is held
  localparam logic         ResetReq   = (`CRC_CLEAR_ON_ASYNC_RESET != 0);
  localparam clear_phase_e ResetPhase = clear_phase_e'(`CRC_RESET_MSG_PHASE);

  logic         req_q;
  logic         wait_q;
  clear_phase_e phase_q;
  sync_vec_t    ack_sync_q;
  logic         ack_sync;

  assign ack_sync = ack_sync_q[`CRC_SYNC_STAGES-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q      <= ResetReq;
      wait_q     <= 1'b0;
      phase_q    <= ResetPhase;
      ack_sync_q <= '0;
    end else begin
      ack_sync_q <= sync_vec_t'({ack_sync_q, link_ack_i});
      if (req_q) begin
        // far side has taken the phase, withdraw the request
        if (ack_sync) begin
          req_q  <= 1'b0;
          wait_q <= 1'b1;
        end
      end else if (wait_q) begin
        if (!ack_sync) begin
          wait_q <= 1'b0;
        end
      end else if (valid_i) begin
        req_q   <= 1'b1;
        phase_q <= phase_i;
      end
    end
  end

  // one cycle pulse when the far side has dropped ack again
  assign ready_o = wait_q && !ack_sync;

  assign link_o = '{req: req_q, phase: phase_q};

  // the offered phase must not move while its request is raised
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_q && valid_i |-> phase_i == phase_q);

endmodule

//--- verification/tb_cdc_reset_ctrlr.sv
//--------------------------------------------------
// testbench of the clear-sequence controller
// ack model and order checks per side, a table of
// triggers applied in a loop, LFSR and timeout
//--------------------------------------------------

`timescale 1ns/100ps

`include "cdc_reset_ctrlr_consts.svh"

// models one CDC side and checks the order of its commands
module side_model
  import cdc_reset_phase_pkg::*;
#(
  parameter string SideName = "a"
) (
  input  logic      clk_i,
  input  side_cmd_t cmd_i,
  input  int        iso_delay_i,
  input  int        clr_delay_i,
  input  int        test_i,
  input  side_ack_t far_ack_i,
  input  int        far_cack_test_i,
  output side_ack_t ack_o,
  output int        cack_test_o,
  output int        pulses_o,
  output int        errors_o
);

  side_ack_t ack_q     = '0;
  int        iso_cnt   = 0;
  int        clr_cnt   = 0;
  int        cack_test = -1;
  int        pulses    = 0;
  int        errors    = 0;
  side_cmd_t prev_cmd  = '0;
  side_ack_t prev_ack  = '0;

  assign ack_o       = ack_q;
  assign cack_test_o = cack_test;
  assign pulses_o    = pulses;
  assign errors_o    = errors;

  // acks are levels that rise a delay after their command and drop with it
  always @(posedge clk_i) begin
    if (!cmd_i.isolate) begin
      iso_cnt           <= 0;
      ack_q.isolate_ack <= 1'b0;
    end else if (iso_cnt >= iso_delay_i) begin
      ack_q.isolate_ack <= 1'b1;
    end else begin
      iso_cnt <= iso_cnt + 1;
    end
    if (!cmd_i.clear) begin
      clr_cnt         <= 0;
      ack_q.clear_ack <= 1'b0;
    end else if (clr_cnt >= clr_delay_i) begin
      ack_q.clear_ack <= 1'b1;
    end else begin
      clr_cnt <= clr_cnt + 1;
    end
  end

  // all values read here were set at the previous edge
  always @(posedge clk_i) begin
    if (ack_q.clear_ack) begin
      cack_test = test_i;
    end
    if (cmd_i.clear && !prev_cmd.clear) begin
      pulses++;
    end
    // clear is only allowed once both sides are isolated
    if (cmd_i.clear) begin
      assert (ack_q.isolate_ack && far_ack_i.isolate_ack) else begin
        $display("side %s: clear is high before both sides acknowledged isolate", SideName);
        errors++;
      end
    end
    // isolate may only fall after clear fell and both sides acked the clear
    if (prev_cmd.isolate && !cmd_i.isolate) begin
      assert (!prev_cmd.clear && cack_test == test_i && far_cack_test_i == test_i) else begin
        $display("side %s: isolate fell before clear was acknowledged on both sides",
                 SideName);
        errors++;
      end
    end
    // a missing ack freezes the phase in place
    if ((prev_cmd.isolate && !prev_ack.isolate_ack) || (prev_cmd.clear && !prev_ack.clear_ack))
    begin
      assert (cmd_i == prev_cmd) else begin
        $display("CHECK FAILED %s_cmd_o: expected 0x%h got 0x%h", SideName, prev_cmd, cmd_i);
        errors++;
      end
    end
    prev_cmd = cmd_i;
    prev_ack = ack_q;
  end

endmodule

module tb_cdc_reset_ctrlr
  import cdc_reset_phase_pkg::*;
();

  typedef enum logic [1:0] {
    TRIG_A_CLEAR,
    TRIG_B_CLEAR,
    TRIG_BOTH_CLEAR,
    TRIG_B_RESET
  } trig_e;

  // one table row, delays in cycles of the side's own clock
  typedef struct packed {
    trig_e trig;
    int    iso_delay;
    int    clr_delay;
    int    min_pulses;
    int    max_pulses;
  } row_t;

  localparam int NumRows     = 8;
  localparam int ResetCycles = 10;
  // largest table delay plus three LFSR bits
  localparam int MaxAckDelay = 19;
  localparam int SeqBound    = 20 + 16 * `CRC_SYNC_STAGES;
  localparam int RowBudget   = 2 * (SeqBound + 4 * MaxAckDelay);
  // the after-reset sequence counts as one more row
  localparam int TimeoutCycles = ResetCycles + (NumRows + 1) * RowBudget;

  logic      a_clk;
  logic      a_rst_n;
  logic      b_clk;
  logic      b_gen_rst_n;
  logic      b_rst_n;
  logic      b_rst_pulse_n = 1'b1;
  logic      a_clear_i     = 1'b0;
  logic      b_clear_i     = 1'b0;
  side_ack_t a_ack;
  side_ack_t b_ack;
  side_cmd_t a_cmd;
  side_cmd_t b_cmd;

  int          test_no     = 0;
  int          a_iso_delay = 2;
  int          a_clr_delay = 2;
  int          b_iso_delay = 2;
  int          b_clr_delay = 2;
  int          a_cack_test;
  int          b_cack_test;
  int          a_pulses;
  int          b_pulses;
  int          a_errors;
  int          b_errors;
  int          main_errors = 0;
  int          failed_tests = 0;
  int          cycle_cnt = 0;
  logic [31:0] lfsr_q = 32'hb232abe7;
  row_t        rows [NumRows];

  tb_clk_gen #(.PeriodNs(20.0), .OffsetNs(0.0), .ResetCycles(ResetCycles)) i_clk_gen_a (
    .clk_o  (a_clk),
    .rst_no (a_rst_n)
  );

  tb_clk_gen #(.PeriodNs(20.0), .OffsetNs(7.0), .ResetCycles(ResetCycles)) i_clk_gen_b (
    .clk_o  (b_clk),
    .rst_no (b_gen_rst_n)
  );

  // b can also be reset on its own during the run
  assign b_rst_n = b_gen_rst_n & b_rst_pulse_n;

  cdc_reset_ctrlr i_cdc_reset_ctrlr (
    .a_clk_i   (a_clk),
    .a_rst_ni  (a_rst_n),
    .a_clear_i (a_clear_i),
    .a_ack_i   (a_ack),
    .a_cmd_o   (a_cmd),
    .b_clk_i   (b_clk),
    .b_rst_ni  (b_rst_n),
    .b_clear_i (b_clear_i),
    .b_ack_i   (b_ack),
    .b_cmd_o   (b_cmd)
  );

  side_model #(.SideName("a")) i_side_a (
    .clk_i (a_clk), .cmd_i (a_cmd), .iso_delay_i (a_iso_delay), .clr_delay_i (a_clr_delay),
    .test_i (test_no), .far_ack_i (b_ack), .far_cack_test_i (b_cack_test), .ack_o (a_ack),
    .cack_test_o (a_cack_test), .pulses_o (a_pulses), .errors_o (a_errors)
  );

  side_model #(.SideName("b")) i_side_b (
    .clk_i (b_clk), .cmd_i (b_cmd), .iso_delay_i (b_iso_delay), .clr_delay_i (b_clr_delay),
    .test_i (test_no), .far_ack_i (a_ack), .far_cack_test_i (a_cack_test), .ack_o (b_ack),
    .cack_test_o (b_cack_test), .pulses_o (b_pulses), .errors_o (b_errors)
  );

  // ------------------------------------------------
  // helpers
  // ------------------------------------------------

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = (val << 1) | int'(lfsr_q[0]);
    end
  endtask

  function automatic int total_errors();
    return main_errors + a_errors + b_errors;
  endfunction

  function automatic string trigger_name(input trig_e trig);
    case (trig)
      TRIG_A_CLEAR:    return "a clear";
      TRIG_B_CLEAR:    return "b clear";
      TRIG_BOTH_CLEAR: return "both clear";
      default:         return "b reset";
    endcase
  endfunction

  // clear pulses last one cycle of the side's own clock
  task automatic apply_trigger(input trig_e trig);
    case (trig)
      TRIG_A_CLEAR: begin
        @(posedge a_clk);
        a_clear_i <= 1'b1;
        @(posedge a_clk);
        a_clear_i <= 1'b0;
      end
      TRIG_B_CLEAR: begin
        @(posedge b_clk);
        b_clear_i <= 1'b1;
        @(posedge b_clk);
        b_clear_i <= 1'b0;
      end
      TRIG_BOTH_CLEAR: begin
        @(posedge a_clk);
        a_clear_i <= 1'b1;
        @(posedge b_clk);
        b_clear_i <= 1'b1;
        @(posedge a_clk);
        a_clear_i <= 1'b0;
        @(posedge b_clk);
        b_clear_i <= 1'b0;
      end
      default: begin
        @(posedge b_clk);
        b_rst_pulse_n <= 1'b0;
        repeat (4) @(posedge b_clk);
        b_rst_pulse_n <= 1'b1;
      end
    endcase
  endtask

  // waits for a sequence to start and then for both sides to come to rest
  task automatic wait_sequence();
    @(posedge a_clk);
    while (a_cmd == '0 && b_cmd == '0) @(posedge a_clk);
    while (a_cmd != '0 || b_cmd != '0) @(posedge a_clk);
    // both side models still have to see the last command edge of their domain
    repeat (2) @(posedge a_clk);
  endtask

  task automatic check_row(input int idx, input string name, input row_t row,
                           input int base_a, input int base_b, input int err_before);
    int pa;
    int pb;
    pa = a_pulses - base_a;
    pb = b_pulses - base_b;
    assert (pa >= row.min_pulses && pa <= row.max_pulses) else begin
      $display("CHECK FAILED a_cmd_o.clear pulses: expected 0x%h to 0x%h got 0x%h",
               row.min_pulses, row.max_pulses, pa);
      main_errors++;
    end
    assert (pb >= row.min_pulses && pb <= row.max_pulses) else begin
      $display("CHECK FAILED b_cmd_o.clear pulses: expected 0x%h to 0x%h got 0x%h",
               row.min_pulses, row.max_pulses, pb);
      main_errors++;
    end
    if (total_errors() == err_before) begin
      $display("test %0d %s: pass", idx, name);
    end else begin
      $display("test %0d %s: FAIL", idx, name);
      failed_tests++;
    end
  endtask

  // ------------------------------------------------
  // timeout
  // ------------------------------------------------

  always @(posedge a_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("timeout: the commands did not return to idle within %0d cycles", TimeoutCycles);
      $display("Errors found");
      $finish;
    end
  end

  // ------------------------------------------------
  // main sequence
  // ------------------------------------------------

  initial begin
    row_t row;
    int   bits;
    int   base_a;
    int   base_b;
    int   err_before;

    // trigger, isolate delay, clear delay, min and max clear pulses per side
    rows[0] = '{TRIG_A_CLEAR, 1, 1, 1, 1};
    rows[1] = '{TRIG_B_CLEAR, 2, 3, 1, 1};
    rows[2] = '{TRIG_BOTH_CLEAR, 1, 2, 1, 2};
    rows[3] = '{TRIG_B_RESET, 2, 2, 1, 1};
    rows[4] = '{TRIG_A_CLEAR, 12, 4, 1, 1};
    rows[5] = '{TRIG_B_CLEAR, 3, 12, 1, 1};
    rows[6] = '{TRIG_BOTH_CLEAR, 10, 10, 1, 2};
    rows[7] = '{TRIG_B_RESET, 6, 9, 1, 1};

    // both sides leave reset in the middle of a sequence
    wait (a_rst_n && b_rst_n);
    wait_sequence();
    check_row(0, "after reset", '{TRIG_B_RESET, 2, 2, 1, 2}, 0, 0, 0);

    for (int i = 0; i < NumRows; i++) begin
      row = rows[i];
      @(posedge a_clk);
      test_no <= i + 1;
      take_bits(3, bits);
      a_iso_delay <= row.iso_delay + bits;
      take_bits(3, bits);
      a_clr_delay <= row.clr_delay + bits;
      take_bits(3, bits);
      b_iso_delay <= row.iso_delay + bits;
      take_bits(3, bits);
      b_clr_delay <= row.clr_delay + bits;
      @(posedge a_clk);
      base_a     = a_pulses;
      base_b     = b_pulses;
      err_before = total_errors();
      apply_trigger(row.trig);
      wait_sequence();
      check_row(i + 1, trigger_name(row.trig), row, base_a, base_b, err_before);
    end

    repeat (5) @(posedge a_clk);
    $display("tests run: %0d, tests failed: %0d, errors: %0d",
             NumRows + 1, failed_tests, total_errors());
    if (total_errors() == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- verification/tb_clk_gen.sv
//--------------------------------------------------
// clock and reset generator for one clock domain
// free running clock with a start offset, reset
// held low for a number of clock cycles
//--------------------------------------------------

`timescale 1ns/100ps

module tb_clk_gen #(
  parameter real PeriodNs    = 20.0,
  parameter real OffsetNs    = 0.0,
  parameter int  ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_no
);

  logic clk_q = 1'b0;
  logic rst_q = 1'b0;

  assign clk_o  = clk_q;
  assign rst_no = rst_q;

  // the offset shifts every edge of this domain against the other one
  initial begin
    #(OffsetNs);
    forever #(PeriodNs / 2.0) clk_q = ~clk_q;
  end

  // reset is released on a rising edge, like any other synchronous input
  initial begin
    repeat (ResetCycles) @(posedge clk_q);
    rst_q <= 1'b1;
  end

endmodule
